// File: design/conv_pkg.sv
package conv_pkg;

	// geometry of one burst
	localparam int IMG_DIM = 4;
	localparam int PAD_DIM = 6;
	localparam int KER_DIM = 3;
	localparam int N_CH = 3;
	localparam int N_KER = 4;
	localparam int N_TAP = 9;
	localparam int N_PIX = 16;
	localparam int N_OUT = 64;
	localparam int N_KBEAT = 36;

	// one window per cycle, channel outer, kernel middle, pixel inner
	localparam int N_ISSUE = N_CH * N_KER * N_PIX;

	// index widths
	localparam int BEAT_W = $clog2(N_KBEAT);
	localparam int CH_W = $clog2(N_CH);
	localparam int KER_W = $clog2(N_KER);
	localparam int PIX_W = $clog2(N_PIX);
	localparam int OUT_W = $clog2(N_OUT);
	localparam int ISSUE_W = $clog2(N_ISSUE);

	// leaky relu scales negatives by 1/8
	localparam int LEAKY_SHIFT = 3;

	// issue cycle to accumulator write, in cycles
	localparam int PIPE_LAT = 3;

	// burst controller states
	typedef enum logic [2:0] {
		IDLE,
		LOAD,
		CALC,
		DRAIN,
		OUTPUT
	} conv_state_e;

	// activation opcode, from opt bit 0
	typedef enum logic {
		RELU,
		LEAKY
	} act_mode_e;

endpackage

// File: design/conv_ctrl.sv
`timescale 1ns/1ps

module conv_ctrl import conv_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_valid_o,
	input  logic [1:0]        opt,
	input  logic              in_valid_i,
	input  logic              in_valid_k,
	output logic              img_wr,
	output logic              ker_wr,
	output logic [BEAT_W-1:0] beat_idx,
	output logic              pad_zero,
	output act_mode_e         mode,
	output logic              clear_acc,
	output logic              calc_valid,
	output logic [CH_W-1:0]   ch_idx,
	output logic [KER_W-1:0]  ker_idx,
	output logic [PIX_W-1:0]  pix_idx,
	output logic              out_issue,
	output logic [OUT_W-1:0]  out_idx
);

	conv_state_e state;
	conv_state_e state_nxt;

	// set once all 16 image beats are in, kernel beats count from then on
	logic img_done;

	// shared step counter for CALC, DRAIN and OUTPUT
	logic [ISSUE_W-1:0] step_cnt;

	// strobes only count in their own phase
	assign img_wr = (state == LOAD) && !img_done && in_valid_i;
	assign ker_wr = (state == LOAD) && img_done && in_valid_k;

	// new burst wipes the result store
	assign clear_acc = (state == IDLE) && in_valid_o;

	assign calc_valid = (state == CALC);
	assign out_issue = (state == OUTPUT);

	// issue order falls out of the counter bits: pixel low, then kernel, then channel
	assign pix_idx = step_cnt[PIX_W-1:0];
	assign ker_idx = step_cnt[PIX_W +: KER_W];
	assign ch_idx = step_cnt[PIX_W+KER_W +: CH_W];
	assign out_idx = step_cnt[OUT_W-1:0];

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: if (in_valid_o) state_nxt = LOAD;
			// last kernel beat starts the calc pass
			LOAD: if (ker_wr && beat_idx == BEAT_W'(N_KBEAT - 1)) state_nxt = CALC;
			CALC: if (step_cnt == ISSUE_W'(N_ISSUE - 1)) state_nxt = DRAIN;
			// let the last windows reach the store
			DRAIN: if (step_cnt == ISSUE_W'(PIPE_LAT - 1)) state_nxt = OUTPUT;
			OUTPUT: if (step_cnt == ISSUE_W'(N_OUT - 1)) state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// step counter restarts on every state change
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			step_cnt <= '0;
		end else if (state_nxt != state) begin
			step_cnt <= '0;
		end else if (state == CALC || state == DRAIN || state == OUTPUT) begin
			step_cnt <= step_cnt + 1'b1;
		end
	end

	// opt word and input beat counting
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pad_zero <= 1'b0;
			mode <= RELU;
			beat_idx <= '0;
			img_done <= 1'b0;
		end else if (state == IDLE) begin
			beat_idx <= '0;
			img_done <= 1'b0;
			if (in_valid_o) begin
				// bit 1 picks zero padding, bit 0 the activation
				pad_zero <= opt[1];
				mode <= act_mode_e'(opt[0]);
			end
		end else if (img_wr) begin
			if (beat_idx == BEAT_W'(N_PIX - 1)) begin
				beat_idx <= '0;
				img_done <= 1'b1;
			end else begin
				beat_idx <= beat_idx + 1'b1;
			end
		end else if (ker_wr) begin
			if (beat_idx == BEAT_W'(N_KBEAT - 1)) begin
				beat_idx <= '0;
			end else begin
				beat_idx <= beat_idx + 1'b1;
			end
		end
	end

endmodule

// File: design/image_buffer.sv
`timescale 1ns/1ps

module image_buffer import conv_pkg::*; #(
	parameter int DATA_W = 16
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         img_wr,
	input  logic [BEAT_W-1:0]            beat_idx,
	input  logic [DATA_W-1:0]            image1,
	input  logic [DATA_W-1:0]            image2,
	input  logic [DATA_W-1:0]            image3,
	input  logic                         pad_zero,
	input  logic [CH_W-1:0]              ch_idx,
	input  logic [PIX_W-1:0]             pix_idx,
	output logic [N_TAP-1:0][DATA_W-1:0] window
);

	// unpadded images, row-major per channel
	logic [DATA_W-1:0] img_mem [N_CH][N_PIX];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int c = 0; c < N_CH; c++) begin
				for (int p = 0; p < N_PIX; p++) begin
					img_mem[c][p] <= '0;
				end
			end
		end else if (img_wr) begin
			// all three channels arrive on the same beat
			img_mem[0][beat_idx[PIX_W-1:0]] <= image1;
			img_mem[1][beat_idx[PIX_W-1:0]] <= image2;
			img_mem[2][beat_idx[PIX_W-1:0]] <= image3;
		end
	end

	// 3x3 window whose top-left sits on the pixel in padded coordinates
	always_comb begin
		int pr;
		int pc;
		int ir;
		int ic;
		logic border;
		for (int t = 0; t < N_TAP; t++) begin
			pr = int'(pix_idx) / IMG_DIM + t / KER_DIM;
			pc = int'(pix_idx) % IMG_DIM + t % KER_DIM;
			border = (pr == 0) || (pr == PAD_DIM - 1) || (pc == 0) || (pc == PAD_DIM - 1);
			// clamp back into the image for edge copy
			if (pr == 0) begin
				ir = 0;
			end else if (pr == PAD_DIM - 1) begin
				ir = IMG_DIM - 1;
			end else begin
				ir = pr - 1;
			end
			if (pc == 0) begin
				ic = 0;
			end else if (pc == PAD_DIM - 1) begin
				ic = IMG_DIM - 1;
			end else begin
				ic = pc - 1;
			end
			if (border && pad_zero) begin
				window[t] = '0;
			end else begin
				window[t] = img_mem[ch_idx][ir * IMG_DIM + ic];
			end
		end
	end

endmodule

// File: design/kernel_buffer.sv
`timescale 1ns/1ps

module kernel_buffer import conv_pkg::*; #(
	parameter int DATA_W = 16
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         ker_wr,
	input  logic [BEAT_W-1:0]            beat_idx,
	input  logic [DATA_W-1:0]            kernel1,
	input  logic [DATA_W-1:0]            kernel2,
	input  logic [DATA_W-1:0]            kernel3,
	input  logic [KER_W-1:0]             ker_idx,
	input  logic [CH_W-1:0]              ch_idx,
	output logic [N_TAP-1:0][DATA_W-1:0] taps
);

	// kernel, channel, tap
	logic [DATA_W-1:0] ker_mem [N_KER][N_CH][N_TAP];

	// beat n is kernel n/9, tap n%9
	logic [KER_W-1:0] wr_ker;
	logic [3:0]       wr_tap;

	assign wr_ker = KER_W'(beat_idx / N_TAP);
	assign wr_tap = 4'(beat_idx % N_TAP);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int k = 0; k < N_KER; k++) begin
				for (int c = 0; c < N_CH; c++) begin
					for (int t = 0; t < N_TAP; t++) begin
						ker_mem[k][c][t] <= '0;
					end
				end
			end
		end else if (ker_wr) begin
			// kernelC carries the channel C slice
			ker_mem[wr_ker][0][wr_tap] <= kernel1;
			ker_mem[wr_ker][1][wr_tap] <= kernel2;
			ker_mem[wr_ker][2][wr_tap] <= kernel3;
		end
	end

	// whole slice presented at once
	always_comb begin
		for (int t = 0; t < N_TAP; t++) begin
			taps[t] = ker_mem[ker_idx][ch_idx][t];
		end
	end

endmodule

// File: design/conv_array.sv
`timescale 1ns/1ps

module conv_array import conv_pkg::*; #(
	parameter int DATA_W = 16,
	parameter int ACC_W = 32
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         clear_acc,
	input  logic                         calc_valid,
	input  logic [KER_W-1:0]             ker_idx,
	input  logic [PIX_W-1:0]             pix_idx,
	input  logic [N_TAP-1:0][DATA_W-1:0] window,
	input  logic [N_TAP-1:0][DATA_W-1:0] taps,
	input  logic [KER_W-1:0]             rd_ker,
	input  logic [PIX_W-1:0]             rd_pix,
	output logic [ACC_W-1:0]             rd_data
);

	// adder tree groups of three products
	localparam int N_GRP = N_TAP / 3;

	// stage 1
	logic                    v1;
	logic [KER_W-1:0]        k1;
	logic [PIX_W-1:0]        p1;
	logic signed [ACC_W-1:0] prod_q [N_TAP];

	// stage 2
	logic                    v2;
	logic [KER_W-1:0]        k2;
	logic [PIX_W-1:0]        p2;
	logic signed [ACC_W-1:0] psum_q [N_GRP];

	// stage 3 input
	logic signed [ACC_W-1:0] window_sum;

	// four feature maps of 16 pixels
	logic signed [ACC_W-1:0] acc_mem [N_KER][N_PIX];

	// valid bits walk with the data
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			v1 <= 1'b0;
			v2 <= 1'b0;
		end else begin
			v1 <= calc_valid;
			v2 <= v1;
		end
	end

	// products sign extended to ACC_W, so sums wrap at ACC_W
	always_ff @(posedge clk) begin
		k1 <= ker_idx;
		p1 <= pix_idx;
		for (int t = 0; t < N_TAP; t++) begin
			prod_q[t] <= $signed(window[t]) * $signed(taps[t]);
		end
	end

	// first tree level, one partial sum per window row
	always_ff @(posedge clk) begin
		k2 <= k1;
		p2 <= p1;
		for (int g = 0; g < N_GRP; g++) begin
			psum_q[g] <= prod_q[3*g] + prod_q[3*g+1] + prod_q[3*g+2];
		end
	end

	always_comb begin
		window_sum = '0;
		for (int g = 0; g < N_GRP; g++) begin
			window_sum = window_sum + psum_q[g];
		end
	end

	// channels accumulate here; same location recurs only 64 issues later
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int k = 0; k < N_KER; k++) begin
				for (int p = 0; p < N_PIX; p++) begin
					acc_mem[k][p] <= '0;
				end
			end
		end else if (clear_acc) begin
			for (int k = 0; k < N_KER; k++) begin
				for (int p = 0; p < N_PIX; p++) begin
					acc_mem[k][p] <= '0;
				end
			end
		end else if (v2) begin
			acc_mem[k2][p2] <= acc_mem[k2][p2] + window_sum;
		end
	end

	// output stage reads directly
	assign rd_data = acc_mem[rd_ker][rd_pix];

endmodule

// File: design/act_out_stage.sv
`timescale 1ns/1ps

module act_out_stage import conv_pkg::*; #(
	parameter int ACC_W = 32
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             out_issue,
	input  logic [OUT_W-1:0] out_idx,
	input  act_mode_e        mode,
	input  logic [ACC_W-1:0] rd_data,
	output logic [KER_W-1:0] rd_ker,
	output logic [PIX_W-1:0] rd_pix,
	output logic             out_valid,
	output logic [ACC_W-1:0] out
);

	// 8x8 output position
	logic [2:0] out_row;
	logic [2:0] out_col;

	logic signed [ACC_W-1:0] act_val;

	assign out_row = out_idx[5:3];
	assign out_col = out_idx[2:0];

	// depth-to-space
	// pixel comes from the 2x2 block position, kernel from the offset inside it
	assign rd_pix = {out_row[2:1], out_col[2:1]};
	assign rd_ker = {out_row[0], out_col[0]};

	always_comb begin
		if (!rd_data[ACC_W-1]) begin
			act_val = $signed(rd_data);
		end else if (mode == LEAKY) begin
			// arithmetic shift keeps the sign
			act_val = $signed(rd_data) >>> LEAKY_SHIFT;
		end else begin
			act_val = '0;
		end
	end

	// one word per issue, one cycle behind
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out <= '0;
		end else begin
			out_valid <= out_issue;
			// bus idles at zero between words
			out <= out_issue ? act_val : '0;
		end
	end

endmodule

// File: design/conv_top.sv
`timescale 1ns/1ps

module conv_top import conv_pkg::*; #(
	parameter int DATA_W = 16,
	parameter int ACC_W = 32
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_valid_o,
	input  logic [1:0]        opt,
	input  logic              in_valid_i,
	input  logic [DATA_W-1:0] image1,
	input  logic [DATA_W-1:0] image2,
	input  logic [DATA_W-1:0] image3,
	input  logic              in_valid_k,
	input  logic [DATA_W-1:0] kernel1,
	input  logic [DATA_W-1:0] kernel2,
	input  logic [DATA_W-1:0] kernel3,
	output logic              out_valid,
	output logic [ACC_W-1:0]  out
);

	// load side
	logic              img_wr;
	logic              ker_wr;
	logic [BEAT_W-1:0] beat_idx;
	logic              pad_zero;
	act_mode_e         mode;

	// calc side
	logic              clear_acc;
	logic              calc_valid;
	logic [CH_W-1:0]   ch_idx;
	logic [KER_W-1:0]  ker_idx;
	logic [PIX_W-1:0]  pix_idx;

	// padded window and matching kernel slice, same cycle as the issue
	logic [N_TAP-1:0][DATA_W-1:0] window;
	logic [N_TAP-1:0][DATA_W-1:0] taps;

	// output side
	logic              out_issue;
	logic [OUT_W-1:0]  out_idx;
	logic [KER_W-1:0]  rd_ker;
	logic [PIX_W-1:0]  rd_pix;
	logic [ACC_W-1:0]  rd_data;

	conv_ctrl i_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid_o (in_valid_o),
		.opt        (opt),
		.in_valid_i (in_valid_i),
		.in_valid_k (in_valid_k),
		.img_wr     (img_wr),
		.ker_wr     (ker_wr),
		.beat_idx   (beat_idx),
		.pad_zero   (pad_zero),
		.mode       (mode),
		.clear_acc  (clear_acc),
		.calc_valid (calc_valid),
		.ch_idx     (ch_idx),
		.ker_idx    (ker_idx),
		.pix_idx    (pix_idx),
		.out_issue  (out_issue),
		.out_idx    (out_idx)
	);

	image_buffer #(.DATA_W(DATA_W)) i_img_buf (
		.clk      (clk),
		.rst_n    (rst_n),
		.img_wr   (img_wr),
		.beat_idx (beat_idx),
		.image1   (image1),
		.image2   (image2),
		.image3   (image3),
		.pad_zero (pad_zero),
		.ch_idx   (ch_idx),
		.pix_idx  (pix_idx),
		.window   (window)
	);

	kernel_buffer #(.DATA_W(DATA_W)) i_ker_buf (
		.clk      (clk),
		.rst_n    (rst_n),
		.ker_wr   (ker_wr),
		.beat_idx (beat_idx),
		.kernel1  (kernel1),
		.kernel2  (kernel2),
		.kernel3  (kernel3),
		.ker_idx  (ker_idx),
		.ch_idx   (ch_idx),
		.taps     (taps)
	);

	conv_array #(.DATA_W(DATA_W), .ACC_W(ACC_W)) i_array (
		.clk        (clk),
		.rst_n      (rst_n),
		.clear_acc  (clear_acc),
		.calc_valid (calc_valid),
		.ker_idx    (ker_idx),
		.pix_idx    (pix_idx),
		.window     (window),
		.taps       (taps),
		.rd_ker     (rd_ker),
		.rd_pix     (rd_pix),
		.rd_data    (rd_data)
	);

	act_out_stage #(.ACC_W(ACC_W)) i_act_out (
		.clk       (clk),
		.rst_n     (rst_n),
		.out_issue (out_issue),
		.out_idx   (out_idx),
		.mode      (mode),
		.rd_data   (rd_data),
		.rd_ker    (rd_ker),
		.rd_pix    (rd_pix),
		.out_valid (out_valid),
		.out       (out)
	);

endmodule

// File: test/conv_model.svh
`ifndef CONV_MODEL_SVH
`define CONV_MODEL_SVH

// model storage, filled by the stimulus generator
// img_v index is channel*16 + pixel, ker_v index is (kernel*3 + channel)*9 + tap
logic signed [DATA_W-1:0] img_v [N_CH*N_PIX];
logic signed [DATA_W-1:0] ker_v [N_KER*N_CH*N_TAP];
logic signed [ACC_W-1:0] exp_out [N_OUT];

// padded 6x6 coordinate back to an image row or column
function automatic int clamp_index(int v);
	if (v < 0) begin
		return 0;
	end else if (v > IMG_DIM - 1) begin
		return IMG_DIM - 1;
	end else begin
		return v;
	end
endfunction

// border is zero or a copy of the nearest image pixel
function automatic longint padded_pixel(int ch, int pr, int pc, bit zero_pad);
	bit border;
	border = (pr == 0) || (pr == PAD_DIM - 1) || (pc == 0) || (pc == PAD_DIM - 1);
	if (zero_pad && border) begin
		return 0;
	end
	return img_v[ch*N_PIX + clamp_index(pr - 1)*IMG_DIM + clamp_index(pc - 1)];
endfunction

// channel-summed convolution for one kernel and pixel, wrapped to ACC_W
function automatic logic signed [ACC_W-1:0] window_sum(int k, int pix, bit zero_pad);
	longint sum;
	longint px;
	sum = 0;
	for (int ch = 0; ch < N_CH; ch++) begin
		for (int t = 0; t < N_TAP; t++) begin
			px = padded_pixel(ch, pix / IMG_DIM + t / KER_DIM, pix % IMG_DIM + t % KER_DIM,
				zero_pad);
			sum += px * longint'(ker_v[(k*N_CH + ch)*N_TAP + t]);
		end
	end
	return sum[ACC_W-1:0];
endfunction

function automatic logic signed [ACC_W-1:0] activate(logic signed [ACC_W-1:0] v, bit leaky);
	if (v >= 0) begin
		return v;
	end else if (leaky) begin
		return v >>> LEAKY_SHIFT;
	end else begin
		return '0;
	end
endfunction

// depth-to-space: 8x8 position to source pixel and kernel
function automatic int out_pixel(int o);
	return ((o / 8) / 2)*IMG_DIM + (o % 8) / 2;
endfunction

function automatic int out_kernel(int o);
	return 2*((o / 8) % 2) + (o % 8) % 2;
endfunction

function automatic void build_expected(logic [1:0] o);
	for (int i = 0; i < N_OUT; i++) begin
		exp_out[i] = activate(window_sum(out_kernel(i), out_pixel(i), o[1]), o[0]);
	end
endfunction

`endif

// File: test/tb_conv.sv
`timescale 1ns/1ps

module tb_conv import conv_pkg::*; ();

	localparam int DATA_W = 16;
	localparam int ACC_W = 32;
	// cycles allowed for out_valid to rise after the last kernel beat
	localparam int WAIT_LIMIT = 500;
	localparam int N_BURST = 8;

	logic              clk;
	logic              rst_n;
	logic              in_valid_o;
	logic [1:0]        opt;
	logic              in_valid_i;
	logic [DATA_W-1:0] image1;
	logic [DATA_W-1:0] image2;
	logic [DATA_W-1:0] image3;
	logic              in_valid_k;
	logic [DATA_W-1:0] kernel1;
	logic [DATA_W-1:0] kernel2;
	logic [DATA_W-1:0] kernel3;
	logic              out_valid;
	logic [ACC_W-1:0]  out;

	int n_checks;
	int n_errors;
	int n_timeouts;
	logic signed [ACC_W-1:0] got_out [N_OUT];

	`include "conv_model.svh"

	conv_top #(.DATA_W(DATA_W), .ACC_W(ACC_W)) i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid_o (in_valid_o),
		.opt        (opt),
		.in_valid_i (in_valid_i),
		.image1     (image1),
		.image2     (image2),
		.image3     (image3),
		.in_valid_k (in_valid_k),
		.kernel1    (kernel1),
		.kernel2    (kernel2),
		.kernel3    (kernel3),
		.out_valid  (out_valid),
		.out        (out)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check_value(input logic signed [63:0] got, input logic signed [63:0] exp,
		input string what, input int idx);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("Error at %0t: %s %0d, got %0d, expected %0d", $time, what, idx, got, exp);
		end
	endtask

	// style 0 full range, 1 negative leaning, 2 one nonzero kernel
	task automatic fill_stimulus(input int style, input int sel);
		for (int i = 0; i < N_CH*N_PIX; i++) begin
			img_v[i] = (style == 1) ? DATA_W'($urandom % 256) : DATA_W'($urandom);
		end
		for (int i = 0; i < N_KER*N_CH*N_TAP; i++) begin
			case (style)
				1: ker_v[i] = ($urandom % 8 == 0) ? DATA_W'($urandom % 64) : -DATA_W'($urandom % 256);
				2: ker_v[i] = (i / (N_CH*N_TAP) == sel) ? DATA_W'($urandom) : '0;
				default: ker_v[i] = DATA_W'($urandom);
			endcase
		end
	endtask

	// opt word, 16 image beats, 36 kernel beats, random gaps everywhere
	task automatic drive_burst(input logic [1:0] o);
		int k;
		int t;
		@(posedge clk);
		in_valid_o <= 1'b1;
		opt <= o;
		@(posedge clk);
		in_valid_o <= 1'b0;
		for (int b = 0; b < N_PIX; b++) begin
			repeat ($urandom % 4) begin
				@(posedge clk);
				in_valid_i <= 1'b0;
			end
			@(posedge clk);
			in_valid_i <= 1'b1;
			image1 <= img_v[b];
			image2 <= img_v[N_PIX + b];
			image3 <= img_v[2*N_PIX + b];
		end
		@(posedge clk);
		in_valid_i <= 1'b0;
		for (int b = 0; b < N_KBEAT; b++) begin
			k = b / N_TAP;
			t = b % N_TAP;
			repeat ($urandom % 4) begin
				@(posedge clk);
				in_valid_k <= 1'b0;
			end
			@(posedge clk);
			in_valid_k <= 1'b1;
			kernel1 <= ker_v[(k*N_CH)*N_TAP + t];
			kernel2 <= ker_v[(k*N_CH + 1)*N_TAP + t];
			kernel3 <= ker_v[(k*N_CH + 2)*N_TAP + t];
		end
		@(posedge clk);
		in_valid_k <= 1'b0;
	endtask

	// outputs are sampled on the falling edge
	task automatic wait_for_output();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!out_valid && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (!out_valid) begin
			$display("timeout: out_valid did not rise within %0d cycles", WAIT_LIMIT);
			n_timeouts++;
		end
	endtask

	// 64 words back to back, then the stream must drop
	task automatic capture_output();
		for (int i = 0; i < N_OUT; i++) begin
			check_value(out_valid, 1, "out_valid low at word", i);
			got_out[i] = out;
			@(negedge clk);
		end
		check_value(out_valid, 0, "out_valid high after word", N_OUT);
		check_value(out, 0, "out nonzero after word", N_OUT);
	endtask

	task automatic run_burst(input logic [1:0] o, input int style);
		int sel;
		int n_neg;
		int n_edge_diff;
		logic signed [ACC_W-1:0] edge_val;
		sel = $urandom % N_KER;
		fill_stimulus(style, sel);
		build_expected(o);
		drive_burst(o);
		wait_for_output();
		if (n_timeouts == 0) begin
			capture_output();
			n_neg = 0;
			n_edge_diff = 0;
			for (int i = 0; i < N_OUT; i++) begin
				check_value(got_out[i], exp_out[i], "out word", i);
				if (got_out[i] < 0) begin
					n_neg++;
				end
				// the same word had the burst used edge-copy padding
				edge_val = activate(window_sum(out_kernel(i), out_pixel(i), 1'b0), o[0]);
				if (got_out[i] !== edge_val) begin
					n_edge_diff++;
				end
				// only the selected kernel's positions may carry data
				if (style == 2 && out_kernel(i) != sel) begin
					check_value(got_out[i], 0, "off-kernel word", i);
				end
			end
			if (o == 2'd0) begin
				check_value(n_neg, 0, "negative words under relu", 0);
			end
			if (o == 2'd1 && style == 1) begin
				check_value(n_neg > 0, 1, "no negative words under leaky relu", 0);
			end
			if (o[1]) begin
				check_value(n_edge_diff > 0, 1, "zero padded output equal to edge copy", 0);
			end
		end
	endtask

	initial begin
		int seed;
		logic [1:0] burst_opt;
		int style;
		seed = 32'h3a180975;
		void'($urandom(seed));
		n_checks = 0;
		n_errors = 0;
		n_timeouts = 0;
		rst_n = 1'b0;
		in_valid_o = 1'b0;
		opt = '0;
		in_valid_i = 1'b0;
		image1 = '0;
		image2 = '0;
		image3 = '0;
		in_valid_k = 1'b0;
		kernel1 = '0;
		kernel2 = '0;
		kernel3 = '0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		// idle after reset, nothing on the output
		for (int i = 0; i < 20; i++) begin
			@(negedge clk);
			check_value(out_valid, 0, "out_valid high while idle, cycle", i);
			check_value(out, 0, "out nonzero while idle, cycle", i);
		end
		// first four bursts walk the opt values, then random back-to-back bursts
		for (int n = 0; n < N_BURST; n++) begin
			if (n_timeouts == 0) begin
				burst_opt = (n < 4) ? 2'(n) : 2'($urandom % 4);
				style = (n == 1 || n == 3) ? 1 : ((n == 4) ? 2 : 0);
				repeat ($urandom % 4) @(posedge clk);
				run_burst(burst_opt, style);
			end
		end
		$display("checks %0d, errors %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
		if (n_errors == 0 && n_timeouts == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// File: project.f
+incdir+test
design/conv_pkg.sv
design/conv_ctrl.sv
design/image_buffer.sv
design/kernel_buffer.sv
design/conv_array.sv
design/act_out_stage.sv
design/conv_top.sv
test/tb_conv.sv
